//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;                // Data and byte address word

    localparam word_t RESET_PC = 16'h0000;      // First fetch address
    localparam word_t PC_STEP  = 16'h0002;      // One instruction, two bytes

    // Top nibble of every instruction
    typedef enum logic [3:0] {
        op_add    = 4'h0,
        op_sub    = 4'h1,
        op_xor    = 4'h2,
        op_red    = 4'h3,
        op_sll    = 4'h4,
        op_sra    = 4'h5,
        op_ror    = 4'h6,
        op_paddsb = 4'h7,
        op_lw     = 4'h8,
        op_sw     = 4'h9,
        op_llb    = 4'hA,
        op_lhb    = 4'hB,
        op_b      = 4'hC,               // Conditional PC-relative branch
        op_and    = 4'hD,
        op_or     = 4'hE,
        op_hlt    = 4'hF                // Stops fetch
    } opcode_e;

    // Branch conditions, tested against z/v/n
    typedef enum logic [2:0] {
        ne     = 3'd0,                  // Z clear
        eq     = 3'd1,                  // Z set
        gt     = 3'd2,                  // Z and N clear
        lt     = 3'd3,                  // N set
        ge     = 3'd4,                  // Z set or N clear
        le     = 3'd5,                  // Z or N set
        ovf    = 3'd6,                  // V set
        uncond = 3'd7
    } cond_e;

    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flags_t;

    // Same 16 bits, two instruction formats
    typedef union packed {
        struct packed {
            opcode_e     opcode;
            logic [3:0]  rd;
            logic [3:0]  rs;
            logic [3:0]  rt;
        } alu;
        struct packed {
            opcode_e           opcode;
            cond_e             cond;
            logic signed [8:0] offset;  // In instructions, not bytes
        } br;
    } instr_u;

    // Fetch packet, {pc_plus_2, instr}
    typedef struct packed {
        word_t pc_plus_2;
        word_t instr;
    } fetch_pkt_t;

    typedef enum logic [1:0] {
        k_alu    = 2'd0,
        k_branch = 2'd1,
        k_halt   = 2'd2
    } kind_e;

    // Packet handed to the back end
    typedef struct packed {
        kind_e kind;
        word_t pc_plus_2;
        word_t instr;
    } issue_pkt_t;

endpackage

//--- logic/fetch.sv
`timescale 1ns/100ps

module fetch (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,          // Credit or run back-pressure
    input  logic                flush,          // Taken branch in decode
    input  cpu_pkg::word_t      branch_target,  // Resolved in decode
    input  cpu_pkg::word_t      instr_in,       // Same-cycle word from imem
    output cpu_pkg::word_t      pc,
    output cpu_pkg::fetch_pkt_t f_out           // To the F/D register
);
    import cpu_pkg::*;

    word_t pc_next;
    word_t pc_plus_2;
    logic  pc_en;
    logic  halt_pc;

    assign pc_en     = ~stall;                  // PC frozen while stalled
    assign pc_plus_2 = pc + PC_STEP;

    // Halt seen at the fetch port, opcode all ones
    assign halt_pc = (instr_in[15:12] == op_hlt);

    // Predict not taken
    // A halt sitting in a branch shadow must not block the redirect
    always_comb begin
        if (halt_pc && !flush) begin
            pc_next = pc;                       // Keep presenting the halt word
        end else if (flush) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus_2;                // Sequential
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    // Decode needs PC+2 as the branch base
    assign f_out = '{pc_plus_2: pc_plus_2, instr: instr_in};

endmodule

//--- logic/imem.sv
`timescale 1ns/100ps

module imem #(
    parameter int IMEM_WORDS = 256              // Depth in 16-bit words
) (
    input  logic           clk,
    input  cpu_pkg::word_t pc,                  // Byte address from fetch
    input  logic           prog_we,             // Program load strobe
    input  cpu_pkg::word_t prog_addr,           // Byte address, same as pc
    input  cpu_pkg::word_t prog_data,
    output cpu_pkg::word_t instr
);
    import cpu_pkg::*;

    localparam int AW = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1;

    word_t mem [IMEM_WORDS];

    // Bit 0 of a byte address is always zero for instructions
    assign instr = mem[pc[AW:1]];               // Combinational read

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr[AW:1]] <= prog_data;
        end
    end

    // Fetch must never run off the end of the loaded program space
    a_pc_in_range : assert property (
        @(posedge clk) !$isunknown(pc) |-> (int'(pc[15:1]) < IMEM_WORDS)
    );

    a_load_in_range : assert property (
        @(posedge clk) prog_we |-> (int'(prog_addr[15:1]) < IMEM_WORDS)
    );

endmodule

//--- logic/fd_pipe.sv
`timescale 1ns/100ps

module fd_pipe (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,          // Hold current contents
    input  logic                flush,          // Squash the wrong-path word
    input  cpu_pkg::fetch_pkt_t f_in,
    output cpu_pkg::fetch_pkt_t d_out,
    output logic                d_valid
);
    import cpu_pkg::*;

    fetch_pkt_t pkt_q;
    logic       valid_q;

    // Valid bit is the only control state here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= ~flush;                  // Bubble behind a taken branch
        end
    end

    // Payload, meaningless while valid is low
    always_ff @(posedge clk) begin
        if (!stall) begin
            pkt_q <= f_in;
        end
    end

    assign d_out   = pkt_q;
    assign d_valid = valid_q;

endmodule

//--- logic/decode_branch.sv
`timescale 1ns/100ps

module decode_branch (
    input  logic                clk,
    input  logic                arst_n,
    input  cpu_pkg::fetch_pkt_t d_in,
    input  logic                d_valid,
    input  logic                stall,          // From issue_credit
    input  cpu_pkg::flags_t     flags,          // Back-end condition flags
    output cpu_pkg::issue_pkt_t dec_pkt,
    output logic                dec_valid,
    output logic                flush,          // Redirect fetch, kill F/D
    output cpu_pkg::word_t      branch_target,
    output logic                halted          // Sticky until reset
);
    import cpu_pkg::*;

    instr_u iw;
    kind_e  kind;
    logic   cond_met;
    logic   issue_go;
    logic   halted_q;

    assign iw = d_in.instr;

    // Opcode from the ALU view, the nibble is shared by both formats
    always_comb begin
        case (iw.alu.opcode)
            op_b:    kind = k_branch;
            op_hlt:  kind = k_halt;
            default: kind = k_alu;              // ALU and memory ops alike
        endcase
    end

    // Condition from the branch view
    always_comb begin
        cond_met = 1'b0;
        case (iw.br.cond)
            ne:     cond_met = ~flags.z;
            eq:     cond_met = flags.z;
            gt:     cond_met = ~flags.z & ~flags.n;
            lt:     cond_met = flags.n;
            ge:     cond_met = flags.z | ~flags.n;
            le:     cond_met = flags.z | flags.n;
            ovf:    cond_met = flags.v;
            uncond: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    // Offset counts instructions, so scale by two
    assign branch_target = d_in.pc_plus_2 + {{6{iw.br.offset[8]}}, iw.br.offset, 1'b0};

    assign dec_valid = d_valid & ~halted_q;     // Nothing after the first halt
    assign issue_go  = dec_valid & ~stall;

    // Only a branch that really issues may redirect
    assign flush = issue_go & (kind == k_branch) & cond_met;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted_q <= 1'b0;
        end else if (issue_go && kind == k_halt) begin
            halted_q <= 1'b1;
        end
    end

    assign halted  = halted_q;
    assign dec_pkt = '{kind: kind, pc_plus_2: d_in.pc_plus_2, instr: d_in.instr};

    // Flush lands while fetch and F/D are moving, so the next decode slot is a bubble
    a_flush_no_stall : assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |-> !stall ##1 !d_valid
    );

endmodule

//--- logic/issue_credit.sv
`timescale 1ns/100ps

module issue_credit #(
    parameter int FE_CREDITS = 4                // Back-end buffer depth
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,            // Low holds the whole front end
    input  cpu_pkg::issue_pkt_t dec_pkt,
    input  logic                dec_valid,
    input  logic                credit_return,  // One credit per high cycle
    output logic                stall,
    output cpu_pkg::issue_pkt_t issue_pkt,
    output logic                issue_valid
);
    import cpu_pkg::*;

    localparam int CW = $clog2(FE_CREDITS + 1);

    logic [CW-1:0] credits;
    logic [CW-1:0] credits_nxt;
    logic          issue;

    assign stall = ~run | (credits == '0);      // No credit, no issue
    assign issue = dec_valid & ~stall;

    // Spend and return can cancel out in one cycle
    always_comb begin
        credits_nxt = credits;
        if (issue && !credit_return) begin
            credits_nxt = credits - 1'b1;
        end else if (!issue && credit_return) begin
            credits_nxt = credits + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits     <= CW'(FE_CREDITS);
            issue_valid <= 1'b0;
        end else begin
            credits     <= credits_nxt;
            issue_valid <= issue;               // One-cycle pulse per packet
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            issue_pkt <= dec_pkt;
        end
    end

    // Back end may not hand back more than it was given
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        (credit_return && !issue) |-> (int'(credits) < FE_CREDITS)
    );

    // Count never climbs above the buffer depth
    a_credits_in_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        int'(credits) <= FE_CREDITS
    );

endmodule

//--- logic/cpu_frontend.sv
`timescale 1ns/100ps

module cpu_frontend #(
    parameter int FE_CREDITS = 4,               // Back-end buffer depth
    parameter int IMEM_WORDS = 256              // Instruction memory depth
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                prog_we,
    input  cpu_pkg::word_t      prog_addr,
    input  cpu_pkg::word_t      prog_data,
    input  cpu_pkg::flags_t     flags,
    input  logic                credit_return,
    output cpu_pkg::issue_pkt_t issue_pkt,
    output logic                issue_valid,
    output logic                halted
);
    import cpu_pkg::*;

    word_t      pc;
    word_t      instr;                          // imem to fetch
    fetch_pkt_t f_out;
    fetch_pkt_t d_in;
    logic       d_valid;
    logic       stall;
    logic       flush;
    word_t      branch_target;
    issue_pkt_t dec_pkt;
    logic       dec_valid;

    fetch u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .instr_in      (instr),
        .pc            (pc),
        .f_out         (f_out)
    );

    imem #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_imem (
        .clk       (clk),
        .pc        (pc),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .instr     (instr)
    );

    fd_pipe u_fd_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (stall),
        .flush   (flush),
        .f_in    (f_out),
        .d_out   (d_in),
        .d_valid (d_valid)
    );

    decode_branch u_decode (
        .clk           (clk),
        .arst_n        (arst_n),
        .d_in          (d_in),
        .d_valid       (d_valid),
        .stall         (stall),
        .flags         (flags),
        .dec_pkt       (dec_pkt),
        .dec_valid     (dec_valid),
        .flush         (flush),
        .branch_target (branch_target),
        .halted        (halted)
    );

    // Stall for the whole front end originates here
    issue_credit #(
        .FE_CREDITS (FE_CREDITS)
    ) u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .run           (run),
        .dec_pkt       (dec_pkt),
        .dec_valid     (dec_valid),
        .credit_return (credit_return),
        .stall         (stall),
        .issue_pkt     (issue_pkt),
        .issue_valid   (issue_valid)
    );

endmodule

//--- verif/frontend_tb.sv
`timescale 1ns/100ps

module frontend_tb;
    import cpu_pkg::*;

    localparam int FE_CREDITS = 4;              // DUT default
    localparam int GOLD_WORDS = 128;
    localparam int WAIT_IDLE  = 20;             // Quiet window after back-pressure and halt

    logic        clk;
    logic        arst_n;
    logic        run;
    logic        prog_we;
    word_t       prog_addr;
    word_t       prog_data;
    flags_t      flags;
    logic        credit_return;
    issue_pkt_t  issue_pkt;
    logic        issue_valid;
    logic        halted;

    logic [15:0] gold [GOLD_WORDS];             // Scenarios from the golden file
    int          ptr;                           // Header of the current scenario
    int          exp_base;                      // First expected packet word
    int          exp_count;
    int          issued;                        // Packets seen in this scenario
    int          owed;                          // Credits held by the back end
    int          gap;                           // Cycles until the next return
    logic        withhold;
    int          cycles;
    int          cycle_limit;

    cpu_frontend DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .flags         (flags),
        .credit_return (credit_return),
        .issue_pkt     (issue_pkt),
        .issue_valid   (issue_valid),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // One clock, outputs sampled and inputs driven 1 ns after the edge
    task automatic next_cycle();
        int e;
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d packets",
                                        cycles, issued, exp_count));
        end
        if (issue_valid) begin
            if (issued >= exp_count) begin
                stop_with_failure("a packet issued beyond the expected sequence");
            end
            e = exp_base + 3 * issued;
            check("issue_pkt.kind", 16'(issue_pkt.kind), gold[e]);
            check("issue_pkt.pc_plus_2", issue_pkt.pc_plus_2, gold[e + 1]);
            check("issue_pkt.instr", issue_pkt.instr, gold[e + 2]);
            issued++;
            owed++;                             // Back end now holds one more
        end
        // Credits go back one at a time after a random gap
        if (!withhold && owed > 0 && gap == 0) begin
            credit_return = 1'b1;
            owed--;
            gap = int'($urandom % 4);
        end else begin
            credit_return = 1'b0;
            if (gap > 0) gap--;
        end
    endtask

    task automatic apply_reset();
        arst_n        = 1'b0;
        run           = 1'b0;
        prog_we       = 1'b0;
        credit_return = 1'b0;
        withhold      = 1'b0;
        owed          = 0;                      // In-flight credits die with reset
        gap           = 0;
        issued        = 0;
        repeat (5) next_cycle();
        arst_n = 1'b1;
    endtask

    function automatic int count_expected();
        int p;
        int total;
        p     = 0;
        total = 0;
        while (gold[p] != 16'h0000) begin
            total += int'(gold[p + 3]);
            p += 4 + int'(gold[p]) + 3 * int'(gold[p + 3]);
        end
        return total;
    endfunction

    task automatic run_scenario();
        int n_prog;
        n_prog = int'(gold[ptr]);
        apply_reset();
        flags     = flags_t'(gold[ptr + 1][2:0]);
        exp_count = int'(gold[ptr + 3]);
        exp_base  = ptr + 4 + n_prog;
        for (int i = 0; i < n_prog; i++) begin  // Load with run low
            prog_we   = 1'b1;
            prog_addr = word_t'(2 * i);
            prog_data = gold[ptr + 4 + i];
            next_cycle();
        end
        prog_we  = 1'b0;
        withhold = gold[ptr + 2][0];
        run      = 1'b1;
        if (withhold) begin
            while (issued < FE_CREDITS) next_cycle();
            repeat (WAIT_IDLE) next_cycle();
            check("issued_count", 16'(issued), 16'(FE_CREDITS));    // Nothing past the credits
            withhold = 1'b0;
        end
        while (issued < exp_count) next_cycle();
        repeat (WAIT_IDLE) next_cycle();        // Extra packets fail inside next_cycle
        if (gold[exp_base + 3 * (exp_count - 1)] == 16'(k_halt)) begin
            check("halted", 16'(halted), 16'h0001);
        end
        ptr = exp_base + 3 * exp_count;
    endtask

    initial begin
        arst_n        = 1'b0;
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        flags         = '0;
        credit_return = 1'b0;
        withhold      = 1'b0;
        cycles        = 0;
        issued        = 0;
        owed          = 0;
        gap           = 0;
        exp_count     = 0;
        exp_base      = 0;
        void'($urandom(32'h9ca));               // Seed for the credit-return gaps
        $readmemh("verif/frontend_golden.txt", gold);
        cycle_limit = 40 * count_expected() + 200;
        ptr = 0;
        while (gold[ptr] != 16'h0000) begin     // Zero header ends the list
            run_scenario();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verif/frontend_golden.txt
// Header: prog_words flags{z,v,n} withhold expected_packets, then program words from 0
// Then one line per issued packet: kind pc_plus_2 instr, a zero header ends the list
// Straight-line ALU code, then halt
0004 0000 0000 0004
0123 1456 2789 F000
0000 0002 0123
0000 0004 1456
0000 0006 2789
0002 0008 F000
// Taken uncond to 0008, taken eq with Z set to 000E
0008 0004 0000 0005
0123 CE02 1111 1222 2333 C201 1444 F000
0000 0002 0123
0001 0004 CE02
0000 000A 2333
0001 000C C201
0002 0010 F000
// Not-taken eq with Z clear
0003 0000 0000 0003
C203 0555 F000
0001 0002 C203
0000 0004 0555
0002 0006 F000
// Credits withheld until the first four packets are out
0008 0000 0001 0008
0101 1202 2303 D404 E505 4606 5707 F000
0000 0002 0101
0000 0004 1202
0000 0006 2303
0000 0008 D404
0000 000A E505
0000 000C 4606
0000 000E 5707
0002 0010 F000
0000 0000 0000 0000

//--- files.f
logic/cpu_pkg.sv
logic/fetch.sv
logic/imem.sv
logic/fd_pipe.sv
logic/decode_branch.sv
logic/issue_credit.sv
logic/cpu_frontend.sv
verif/frontend_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := frontend_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# The pipeline status is the status of grep, so a missing pass line fails the target
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
